/* verilog/ce_pkg.sv */
package ce_pkg;

	localparam int lanes = 2;
	localparam int pixel_w = 16;
	localparam int weight_w = 16;
	localparam int acc_w = 48;
	localparam int max_window = 8;

	// window length in beats with a legal range of 1 to max_window
	typedef logic [3:0] window_len_t;

	typedef enum logic
	{
		mode_conv = 1'b0,
		mode_pool = 1'b1
	} mode_t;

	// the pixel sits in the upper half of a convolution word
	typedef struct packed
	{
		logic signed [pixel_w-1:0] pixel;
		logic signed [weight_w-1:0] weight;
	} conv_word_t;

	typedef struct packed
	{
		logic signed [pixel_w-1:0] pixel_a;
		logic signed [pixel_w-1:0] pixel_b;
	} pool_word_t;

	// one lane word, read as pixel and weight or as a pair of pixels
	typedef union packed
	{
		conv_word_t conv;
		pool_word_t pool;
	} lane_word_u;

	typedef lane_word_u [lanes-1:0] lane_words_t;

	typedef logic signed [acc_w-1:0] acc_t;

	// per beat control, shared by every lane
	typedef struct packed
	{
		logic valid;
		logic first;
		logic last;
		mode_t mode;
	} beat_ctrl_t;

	typedef struct packed
	{
		logic done;
		acc_t value;
	} lane_out_t;

	// window close mark, mode and cascade lined up with the lane totals
	typedef struct packed
	{
		logic done;
		mode_t mode;
		acc_t cascade;
	} reduce_ctrl_t;

endpackage

/* verilog/ce_window_ctrl.sv */
`timescale 1ns/1ns

module ce_window_ctrl
(
	input logic clk_5x,
	input logic rst,
	input logic new_map,
	input ce_pkg::mode_t mode,
	input ce_pkg::window_len_t window_len,
	input logic in_valid,
	input ce_pkg::acc_t cascade_in,
	output ce_pkg::beat_ctrl_t beat_ctrl,
	output ce_pkg::reduce_ctrl_t reduce_ctrl
);

	ce_pkg::mode_t mode_reg;
	ce_pkg::window_len_t len_reg;
	logic [$clog2(ce_pkg::max_window)-1:0] beat_cnt;
	logic last_beat;

	logic done_d1;
	logic done_d2;
	ce_pkg::mode_t mode_d1;
	ce_pkg::mode_t mode_d2;
	ce_pkg::acc_t cascade_d1;
	ce_pkg::acc_t cascade_d2;

	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			mode_reg <= ce_pkg::mode_conv;
			len_reg <= 4'd4;
		end
		else if (new_map)
		begin
			mode_reg <= mode;
			len_reg <= window_len;
		end
	end

	// beat_cnt is the position of the next beat inside its window
	always_ff @(posedge clk_5x)
	begin
		if (rst || new_map)
		begin
			beat_cnt <= '0;
		end
		else if (in_valid)
		begin
			if (last_beat)
			begin
				beat_cnt <= '0;
			end
			else
			begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	assign last_beat = ({1'b0, beat_cnt} == (len_reg - 4'd1));

	assign beat_ctrl.valid = in_valid;
	assign beat_ctrl.first = in_valid && (beat_cnt == '0);
	assign beat_ctrl.last = in_valid && last_beat;
	assign beat_ctrl.mode = mode_reg;

	// two stages to match the product register and the accumulator in each lane
	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			done_d1 <= 1'b0;
			done_d2 <= 1'b0;
			mode_d1 <= ce_pkg::mode_conv;
			mode_d2 <= ce_pkg::mode_conv;
		end
		else
		begin
			done_d1 <= in_valid && last_beat;
			done_d2 <= done_d1;
			mode_d1 <= mode_reg;
			mode_d2 <= mode_d1;
		end
	end

	// cascade is taken with the last beat of a window and held until the next one
	always_ff @(posedge clk_5x)
	begin
		if (in_valid && last_beat)
		begin
			cascade_d1 <= cascade_in;
		end
		if (done_d1)
		begin
			cascade_d2 <= cascade_d1;
		end
	end

	assign reduce_ctrl.done = done_d2;
	assign reduce_ctrl.mode = mode_d2;
	assign reduce_ctrl.cascade = cascade_d2;

endmodule

/* verilog/ce_lane.sv */
`timescale 1ns/1ns

module ce_lane
(
	input logic clk_5x,
	input logic rst,
	input ce_pkg::beat_ctrl_t beat_ctrl,
	input ce_pkg::lane_word_u word,
	output ce_pkg::lane_out_t lane_out
);

	logic signed [ce_pkg::pixel_w+ce_pkg::weight_w-1:0] product;
	logic signed [ce_pkg::pixel_w-1:0] pair_max;

	ce_pkg::acc_t term;
	logic term_valid;
	logic term_first;
	logic term_last;
	ce_pkg::mode_t term_mode;

	ce_pkg::acc_t acc;
	logic acc_done;

	// full 32 bit product, so no rounding before the accumulator
	assign product = word.conv.pixel * word.conv.weight;

	assign pair_max = (word.pool.pixel_a > word.pool.pixel_b) ?
		word.pool.pixel_a : word.pool.pixel_b;

	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			term_valid <= 1'b0;
			term_first <= 1'b0;
			term_last <= 1'b0;
			term_mode <= ce_pkg::mode_conv;
		end
		else
		begin
			term_valid <= beat_ctrl.valid;
			term_first <= beat_ctrl.first;
			term_last <= beat_ctrl.last;
			term_mode <= beat_ctrl.mode;
		end
	end

	always_ff @(posedge clk_5x)
	begin
		if (beat_ctrl.valid)
		begin
			if (beat_ctrl.mode == ce_pkg::mode_conv)
			begin
				term <= ce_pkg::acc_t'(product);
			end
			else
			begin
				term <= ce_pkg::acc_t'(pair_max);
			end
		end
	end

	// a first beat loads, so no clear is needed between windows
	always_ff @(posedge clk_5x)
	begin
		if (term_valid)
		begin
			if (term_first)
			begin
				acc <= term;
			end
			else if (term_mode == ce_pkg::mode_conv)
			begin
				acc <= acc + term;
			end
			else if (term > acc)
			begin
				acc <= term;
			end
		end
	end

	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			acc_done <= 1'b0;
		end
		else
		begin
			acc_done <= term_last;
		end
	end

	assign lane_out.done = acc_done;
	assign lane_out.value = acc;

endmodule

/* verilog/ce_reduce.sv */
`timescale 1ns/1ns

module ce_reduce
(
	input logic clk_5x,
	input logic rst,
	input ce_pkg::lane_out_t [ce_pkg::lanes-1:0] lane_outs,
	input ce_pkg::reduce_ctrl_t reduce_ctrl,
	output logic out_valid,
	output ce_pkg::acc_t result
);

	ce_pkg::acc_t lane_sum;
	ce_pkg::acc_t lane_max;

	// the cascade from the previous element is the starting value of the sum
	always_comb
	begin
		lane_sum = reduce_ctrl.cascade;
		for (int i = 0; i < ce_pkg::lanes; i++)
		begin
			lane_sum = lane_sum + lane_outs[i].value;
		end
	end

	always_comb
	begin
		lane_max = lane_outs[0].value;
		for (int i = 1; i < ce_pkg::lanes; i++)
		begin
			if (lane_outs[i].value > lane_max)
			begin
				lane_max = lane_outs[i].value;
			end
		end
	end

	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= reduce_ctrl.done;
		end
	end

	// result holds its value until the next window closes
	always_ff @(posedge clk_5x)
	begin
		if (reduce_ctrl.done)
		begin
			if (reduce_ctrl.mode == ce_pkg::mode_conv)
			begin
				result <= lane_sum;
			end
			else
			begin
				result <= lane_max;
			end
		end
	end

endmodule

/* verilog/ce_top.sv */
`timescale 1ns/1ns

module ce_top
(
	input logic clk_5x,
	input logic rst,
	input logic new_map,
	input ce_pkg::mode_t mode,
	input ce_pkg::window_len_t window_len,
	input logic in_valid,
	input ce_pkg::lane_words_t in_words,
	input ce_pkg::acc_t cascade_in,
	output logic out_valid,
	output ce_pkg::acc_t result
);

	ce_pkg::beat_ctrl_t beat_ctrl;
	ce_pkg::reduce_ctrl_t reduce_ctrl;
	ce_pkg::lane_out_t [ce_pkg::lanes-1:0] lane_outs;

	ce_window_ctrl u_ctrl
	(
		.clk_5x (clk_5x),
		.rst (rst),
		.new_map (new_map),
		.mode (mode),
		.window_len (window_len),
		.in_valid (in_valid),
		.cascade_in (cascade_in),
		.beat_ctrl (beat_ctrl),
		.reduce_ctrl (reduce_ctrl)
	);

	// every lane sees the same beat control and its own slice of the input
	generate
		for (genvar g = 0; g < ce_pkg::lanes; g++)
		begin : g_lane
			ce_lane u_lane
			(
				.clk_5x (clk_5x),
				.rst (rst),
				.beat_ctrl (beat_ctrl),
				.word (in_words[g]),
				.lane_out (lane_outs[g])
			);
		end
	endgenerate

	ce_reduce u_reduce
	(
		.clk_5x (clk_5x),
		.rst (rst),
		.lane_outs (lane_outs),
		.reduce_ctrl (reduce_ctrl),
		.out_valid (out_valid),
		.result (result)
	);

endmodule

/* testbench/ce_props.sv */
`timescale 1ns/1ns

module ce_props
(
	input logic clk_5x,
	input logic rst,
	input logic new_map,
	input ce_pkg::window_len_t window_len,
	input logic out_valid
);

	int fail_count = 0;
	ce_pkg::window_len_t len_seen;

	// local copy of the latched window length
	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			len_seen <= 4'd4;
		end
		else if (new_map)
		begin
			len_seen <= window_len;
		end
	end

	// the second cycle covers the first edge after reset is released
	a_reset_quiet: assert property (@(posedge clk_5x) rst |=> !out_valid ##1 !out_valid)
		else
		begin
			fail_count++;
			$error("out_valid high during reset or in the cycle after it");
		end

	a_len_legal: assert property (@(posedge clk_5x) disable iff (rst)
		new_map |-> (window_len >= 4'd1 && window_len <= ce_pkg::max_window))
		else
		begin
			fail_count++;
			$error("new_map given with an illegal window length");
		end

	// with windows longer than one beat, results cannot come back to back
	a_no_adjacent: assert property (@(posedge clk_5x) disable iff (rst)
		(out_valid && len_seen > 4'd1) |=> !out_valid)
		else
		begin
			fail_count++;
			$error("out_valid high in two adjacent cycles");
		end

endmodule

bind ce_top ce_props u_props
(
	.clk_5x (clk_5x),
	.rst (rst),
	.new_map (new_map),
	.window_len (window_len),
	.out_valid (out_valid)
);

/* testbench/ce_tb.sv */
`timescale 1ns/1ns

module ce_tb;

	typedef struct packed
	{
		ce_pkg::lane_words_t [ce_pkg::max_window-1:0] words;
		ce_pkg::window_len_t len;
		ce_pkg::mode_t mode;
		ce_pkg::acc_t cascade;
	} window_rec_t;

	localparam int kind_random = 0;
	localparam int kind_extreme = 1;
	localparam int kind_negative = 2;

	// beats per test group, then worst case gaps, config idles and reset
	localparam int beat_cycles = 20 * 1 + 6 * 8 + 6 * 3 + 5 * 5 + 3 * 2 + 3 * 4 + 3 * 3
		+ 4 * 5 + 4 * 6;
	localparam int gap_beats = 4 * 5 + 4 * 6;
	localparam int config_count = 9;
	localparam int timeout_cycles = 16 + beat_cycles + 2 * gap_beats + 5 * config_count
		+ 10 + 100;

	logic clk_5x;
	logic rst;
	logic new_map;
	ce_pkg::mode_t mode;
	ce_pkg::window_len_t window_len;
	logic in_valid;
	ce_pkg::lane_words_t in_words;
	ce_pkg::acc_t cascade_in;
	logic out_valid;
	ce_pkg::acc_t result;

	int cycle_count = 0;
	window_rec_t win_q[$];
	string name_q[$];
	int due_q[$];
	ce_pkg::mode_t cur_mode;
	ce_pkg::window_len_t cur_len;

	ce_top DUT
	(
		.clk_5x (clk_5x),
		.rst (rst),
		.new_map (new_map),
		.mode (mode),
		.window_len (window_len),
		.in_valid (in_valid),
		.in_words (in_words),
		.cascade_in (cascade_in),
		.out_valid (out_valid),
		.result (result)
	);

	initial
	begin
		clk_5x = 1'b0;
		forever #20 clk_5x = ~clk_5x;
	end

	task automatic fail_run();
		$display("** FAIL **");
		$fatal(1, "stopping the run");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			fail_run();
		end
	endtask

	always @(posedge clk_5x)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			fail_run();
		end
	end

	function automatic logic [15:0] extreme_half();
		case ($urandom_range(2, 0))
			0: return 16'h8000;
			1: return 16'h7fff;
			default: return 16'h8001;
		endcase
	endfunction

	function automatic logic [31:0] make_word(input int kind);
		if (kind == kind_extreme)
		begin
			return {extreme_half(), extreme_half()};
		end
		else if (kind == kind_negative)
		begin
			return {1'b1, 15'($urandom()), 1'b1, 15'($urandom())};
		end
		return $urandom();
	endfunction

	// conv sums pixel times weight over every lane and beat, pool takes the largest pixel
	function automatic ce_pkg::acc_t expected_result(input window_rec_t w);
		longint total;
		longint best;
		longint px_hi;
		longint px_lo;
		logic [31:0] raw;
		int b;
		int l;
		total = w.cascade;
		best = -(longint'(1) << 40);
		for (b = 0; b < w.len; b++)
		begin
			for (l = 0; l < ce_pkg::lanes; l++)
			begin
				raw = w.words[b][l];
				px_hi = $signed(raw[31:16]);
				px_lo = $signed(raw[15:0]);
				total = total + px_hi * px_lo;
				if (px_hi > best)
				begin
					best = px_hi;
				end
				if (px_lo > best)
				begin
					best = px_lo;
				end
			end
		end
		if (w.mode == ce_pkg::mode_conv)
		begin
			return total[47:0];
		end
		return best[47:0];
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk_5x);
			in_valid = 1'b0;
			new_map = 1'b0;
		end
	endtask

	task automatic configure(input ce_pkg::mode_t m, input ce_pkg::window_len_t len);
		idle_cycles(4);
		@(negedge clk_5x);
		in_valid = 1'b0;
		new_map = 1'b1;
		mode = m;
		window_len = len;
		cur_mode = m;
		cur_len = len;
	endtask

	task automatic send_window(input string name, input int kind, input bit gaps);
		window_rec_t rec;
		int gap;
		int b;
		int l;
		rec = '0;
		rec.len = cur_len;
		rec.mode = cur_mode;
		rec.cascade = ce_pkg::acc_t'({$urandom(), $urandom()});
		for (b = 0; b < cur_len; b++)
		begin
			for (l = 0; l < ce_pkg::lanes; l++)
			begin
				rec.words[b][l] = make_word(kind);
			end
			if (gaps)
			begin
				gap = $urandom_range(2, 0);
				idle_cycles(gap);
			end
			@(negedge clk_5x);
			new_map = 1'b0;
			in_valid = 1'b1;
			in_words = rec.words[b];
			cascade_in = rec.cascade;
		end
		// the last beat is sampled on the next edge and the result shows 2 edges later
		win_q.push_back(rec);
		name_q.push_back(name);
		due_q.push_back(cycle_count + 3);
	endtask

	always @(negedge clk_5x)
	begin : compare_results
		window_rec_t rec;
		string name;
		int due;
		if (DUT.u_props.fail_count != 0)
		begin
			$display("an assertion in ce_props failed");
			fail_run();
		end
		else if (out_valid === 1'b1)
		begin
			if (win_q.size() == 0)
			begin
				$display("out_valid went high with no window outstanding");
				fail_run();
			end
			else
			begin
				rec = win_q.pop_front();
				name = name_q.pop_front();
				due = due_q.pop_front();
				check_value(name, expected_result(rec), result);
				check_value({name, " latency"}, due, cycle_count);
			end
		end
	end

	initial
	begin
		void'($urandom(32'hffd26577));
		rst = 1'b1;
		new_map = 1'b0;
		mode = ce_pkg::mode_conv;
		window_len = 4'd4;
		in_valid = 1'b0;
		in_words = '0;
		cascade_in = '0;
		cur_mode = ce_pkg::mode_conv;
		cur_len = 4'd4;
		repeat (16) @(posedge clk_5x);
		@(negedge clk_5x);
		rst = 1'b0;

		configure(ce_pkg::mode_conv, 4'd1);
		repeat (20) send_window("conv_len1", kind_random, 1'b0);

		configure(ce_pkg::mode_conv, 4'd8);
		repeat (4) send_window("conv_len8", kind_random, 1'b0);
		repeat (2) send_window("conv_len8_extreme", kind_extreme, 1'b0);

		configure(ce_pkg::mode_pool, 4'd3);
		repeat (5) send_window("pool_len3", kind_random, 1'b0);
		send_window("pool_len3_negative", kind_negative, 1'b0);
		configure(ce_pkg::mode_pool, 4'd5);
		repeat (4) send_window("pool_len5", kind_random, 1'b0);
		send_window("pool_len5_negative", kind_negative, 1'b0);

		configure(ce_pkg::mode_conv, 4'd2);
		repeat (3) send_window("switch_conv_len2", kind_random, 1'b0);
		configure(ce_pkg::mode_pool, 4'd4);
		repeat (3) send_window("switch_pool_len4", kind_random, 1'b0);
		configure(ce_pkg::mode_conv, 4'd3);
		repeat (3) send_window("switch_conv_len3", kind_random, 1'b0);

		configure(ce_pkg::mode_conv, 4'd5);
		repeat (4) send_window("gaps_conv_len5", kind_random, 1'b1);
		configure(ce_pkg::mode_pool, 4'd6);
		repeat (4) send_window("gaps_pool_len6", kind_random, 1'b1);

		// the pipeline is three edges deep, so a few idle cycles drain it
		idle_cycles(6);
		if (win_q.size() != 0)
		begin
			$display("results missing for %0d windows", win_q.size());
			fail_run();
		end
		else if (DUT.u_props.fail_count != 0)
		begin
			$display("%0d assertion failures in ce_props", DUT.u_props.fail_count);
			fail_run();
		end
		else
		begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

/* compile.f */
verilog/ce_pkg.sv
verilog/ce_window_ctrl.sv
verilog/ce_lane.sv
verilog/ce_reduce.sv
verilog/ce_top.sv
testbench/ce_props.sv
testbench/ce_tb.sv
